// File: all.f
hw/hyper_read_pkg.sv
hw/hyper_rd_fifo.sv
hw/hyper_rd_arbiter.sv
hw/hyper_ddr_capture.sv
hw/hyper_burst_ctrl.sv
hw/hyper_read_top.sv
tests/hyper_ram_model.sv
tests/tb_hyper_read.sv

// File: hw/hyper_burst_ctrl.sv
`timescale 1ns/100ps

module hyper_burst_ctrl (
    input  logic                       clk_rwds,
    input  logic                       resetReadModule,

    input  logic                       grant_valid_i,
    output logic                       grant_ready_o,
    input  hyper_read_pkg::rd_req_t    grant_req_i,
    input  hyper_read_pkg::client_id_t grant_id_i,

    output logic                       hyper_cs_n_o,
    output logic                       hyper_cmd_valid_o,
    output hyper_read_pkg::hyper_cmd_t hyper_cmd_o,

    input  logic                       word_valid_i,
    output logic                       word_ready_o,
    input  hyper_read_pkg::rd_word_t   word_i,

    output logic [1:0]                 resp_valid_o,
    input  logic [1:0]                 resp_ready_i,
    output hyper_read_pkg::rd_word_t   resp_o
);

    import hyper_read_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BURST,
        ST_DRAIN
    } state_e;

    state_e           state_q;
    client_id_t       id_q;
    hyper_cmd_t       cmd_q;
    logic             cmd_valid_q;
    logic             cs_n_q;
    logic [LEN_W-1:0] cap_cnt_q;
    logic [LEN_W-1:0] dlv_cnt_q;
    logic [15:0]      out_data_q;
    logic [1:0]       out_valid_q;
    logic             grant_fire;
    logic             pop_fire;
    logic             out_fire;
    logic             cap_last;
    logic             dlv_last;

    // New bursts only once the previous one has fully left
    assign grant_ready_o = (state_q == ST_IDLE);
    assign grant_fire    = grant_valid_i && grant_ready_o;

    assign out_fire     = |(out_valid_q & resp_ready_i);
    assign word_ready_o = (state_q == ST_BURST) && ((out_valid_q == 2'b00) || out_fire);
    assign pop_fire     = word_valid_i && word_ready_o;

    assign cap_last = (cap_cnt_q == cmd_q.len);
    assign dlv_last = (dlv_cnt_q == cmd_q.len);

    assign hyper_cs_n_o      = cs_n_q;
    assign hyper_cmd_valid_o = cmd_valid_q;
    assign hyper_cmd_o       = cmd_q;

    assign resp_valid_o = out_valid_q;
    assign resp_o       = '{data: out_data_q, last: dlv_last};

    always_ff @(posedge clk_rwds) begin
        if (grant_fire) begin
            cmd_q <= '{addr: grant_req_i.addr, len: grant_req_i.len};
        end
        if (pop_fire) begin
            out_data_q <= word_i.data;
        end
    end

    always_ff @(posedge clk_rwds or posedge resetReadModule) begin
        if (resetReadModule) begin
            state_q     <= ST_IDLE;
            id_q        <= 1'b0;
            cmd_valid_q <= 1'b0;
            cs_n_q      <= 1'b1;
            cap_cnt_q   <= '0;
            dlv_cnt_q   <= '0;
            out_valid_q <= 2'b00;
        end else begin
            // One-cycle command pulse after the grant
            cmd_valid_q <= grant_fire;
            if (out_fire) begin
                out_valid_q <= 2'b00;
            end
            // Route the word to the port of the client that owns the burst
            if (pop_fire) begin
                out_valid_q <= id_q ? 2'b10 : 2'b01;
            end
            case (state_q)
                ST_IDLE: begin
                    if (grant_fire) begin
                        state_q   <= ST_BURST;
                        id_q      <= grant_id_i;
                        cs_n_q    <= 1'b0;
                        cap_cnt_q <= '0;
                        dlv_cnt_q <= '0;
                    end
                end
                ST_BURST: begin
                    if (pop_fire) begin
                        cap_cnt_q <= cap_cnt_q + 1'b1;
                        if (cap_last) begin
                            state_q <= ST_DRAIN;
                            cs_n_q  <= 1'b1;
                        end
                    end
                    if (out_fire) begin
                        dlv_cnt_q <= dlv_cnt_q + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    // Wait for the final word to be taken
                    if (out_fire) begin
                        dlv_cnt_q <= dlv_cnt_q + 1'b1;
                        if (dlv_last) begin
                            state_q <= ST_IDLE;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // The word buffer only holds data while a burst is being read
    a_word_in_burst: assert property (@(posedge clk_rwds) disable iff (resetReadModule)
        word_valid_i |-> (state_q == ST_BURST))
        else $error("word arrived outside a burst");

    a_resp_hold: assert property (@(posedge clk_rwds) disable iff (resetReadModule)
        (resp_valid_o != 2'b00) && !out_fire |=>
            (resp_valid_o == $past(resp_valid_o)) && $stable(resp_o))
        else $error("stalled response changed before acceptance");

endmodule

// File: hw/hyper_ddr_capture.sv
`timescale 1ns/100ps

module hyper_ddr_capture (
    input  logic                     clk_rwds,
    input  logic                     resetReadModule,

    input  logic [7:0]               hyper_dq_i,
    input  logic                     hyper_rwds_en_i,

    output logic                     word_valid_o,
    output hyper_read_pkg::rd_word_t word_o
);

    logic [7:0]  hi_byte_q;
    logic [7:0]  lo_byte_q;
    logic [15:0] word_data_q;
    logic        hi_valid_q;
    logic        lo_valid_q;
    logic        word_valid_q;

    // Rising edge carries the upper byte
    always_ff @(posedge clk_rwds or posedge resetReadModule) begin
        if (resetReadModule) begin
            hi_valid_q   <= 1'b0;
            word_valid_q <= 1'b0;
        end else begin
            hi_valid_q   <= hyper_rwds_en_i;
            word_valid_q <= lo_valid_q;
        end
    end

    // Both halves are joined at the rising edge after the lower byte
    always_ff @(posedge clk_rwds) begin
        hi_byte_q   <= hyper_dq_i;
        word_data_q <= {hi_byte_q, lo_byte_q};
    end

    // Falling edge completes the word only if the upper half was strobed
    always_ff @(negedge clk_rwds or posedge resetReadModule) begin
        if (resetReadModule) begin
            lo_valid_q <= 1'b0;
        end else begin
            lo_valid_q <= hyper_rwds_en_i && hi_valid_q;
        end
    end

    always_ff @(negedge clk_rwds) begin
        lo_byte_q <= hyper_dq_i;
    end

    assign word_valid_o = word_valid_q;
    // The controller fills in the last flag
    assign word_o = '{data: word_data_q, last: 1'b0};

endmodule

// File: hw/hyper_rd_arbiter.sv
`timescale 1ns/100ps

module hyper_rd_arbiter (
    input  logic                       clk_rwds,
    input  logic                       resetReadModule,

    input  logic [1:0]                 req_valid_i,
    output logic [1:0]                 req_ready_o,
    input  hyper_read_pkg::rd_req_t    req0_i,
    input  hyper_read_pkg::rd_req_t    req1_i,

    output logic                       grant_valid_o,
    input  logic                       grant_ready_i,
    output hyper_read_pkg::rd_req_t    grant_req_o,
    output hyper_read_pkg::client_id_t grant_id_o
);

    import hyper_read_pkg::*;

    client_id_t last_q;
    client_id_t sel;

    // On a tie the client not served last wins
    always_comb begin
        if (&req_valid_i) begin
            sel = ~last_q;
        end else begin
            sel = req_valid_i[1];
        end
    end

    assign grant_valid_o = |req_valid_i;
    assign grant_req_o   = sel ? req1_i : req0_i;
    assign grant_id_o    = sel;

    // Only the selected queue sees the controller's ready
    assign req_ready_o[0] = grant_ready_i && !sel;
    assign req_ready_o[1] = grant_ready_i && sel;

    // Start as if client 1 went last so client 0 wins the first tie
    always_ff @(posedge clk_rwds or posedge resetReadModule) begin
        if (resetReadModule) begin
            last_q <= 1'b1;
        end else if (grant_valid_o && grant_ready_i) begin
            last_q <= sel;
        end
    end

    // A client left waiting by an accepted grant is the one offered next
    a_round_robin: assert property (@(posedge clk_rwds) disable iff (resetReadModule)
        grant_valid_o && grant_ready_i && (&req_valid_i) |=> grant_id_o != $past(grant_id_o))
        else $error("waiting client was not offered after a contested grant");

endmodule

// File: hw/hyper_rd_fifo.sv
`timescale 1ns/100ps

module hyper_rd_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk_rwds,
    input  logic resetReadModule,

    input  logic push_valid_i,
    output logic push_ready_o,
    input  T     push_data_i,

    output logic pop_valid_o,
    input  logic pop_ready_i,
    output T     pop_data_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_fire;
    logic             pop_fire;

    assign push_ready_o = (count_q != CNT_W'(DEPTH));
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem_q[rd_ptr_q];

    assign push_fire = push_valid_i && push_ready_o;
    assign pop_fire  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk_rwds) begin
        if (push_fire) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk_rwds or posedge resetReadModule) begin
        if (resetReadModule) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // An offer that is refused must still be there next cycle.
    // The DQ side cannot hold a word, so on the word buffer this is the overflow check
    a_no_overflow: assert property (@(posedge clk_rwds) disable iff (resetReadModule)
        push_valid_i && !push_ready_o |=> push_valid_i && $stable(push_data_i))
        else $error("push into full FIFO was lost");

    a_pop_known: assert property (@(posedge clk_rwds) disable iff (resetReadModule)
        pop_valid_o |-> !$isunknown(pop_data_o))
        else $error("FIFO presents unknown data");

endmodule

// File: hw/hyper_read_pkg.sv
package hyper_read_pkg;

    // Word address width on the bus
    localparam int ADDR_W = 32;

    // Burst length field, value plus one gives the word count
    localparam int LEN_W = 5;

    // Longest burst in words
    localparam int MAX_BURST = 16;

    // Word buffer holds one full burst
    localparam int WORD_FIFO_DEPTH = MAX_BURST;

    // Pending requests per client
    localparam int REQ_FIFO_DEPTH = 4;

    // Read request from a client
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } rd_req_t;

    // Command driven towards the HyperBus device
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
    } hyper_cmd_t;

    // One 16-bit data word, last marks the end of a burst
    typedef struct packed {
        logic [15:0] data;
        logic        last;
    } rd_word_t;

    // Index of a read client
    typedef logic client_id_t;

endpackage

// File: hw/hyper_read_top.sv
`timescale 1ns/100ps

module hyper_read_top (
    input  logic                       clk_rwds,
    input  logic                       resetReadModule,

    input  logic                       req0_valid_i,
    output logic                       req0_ready_o,
    input  hyper_read_pkg::rd_req_t    req0_i,
    input  logic                       req1_valid_i,
    output logic                       req1_ready_o,
    input  hyper_read_pkg::rd_req_t    req1_i,

    output logic                       resp0_valid_o,
    input  logic                       resp0_ready_i,
    output hyper_read_pkg::rd_word_t   resp0_o,
    output logic                       resp1_valid_o,
    input  logic                       resp1_ready_i,
    output hyper_read_pkg::rd_word_t   resp1_o,

    output logic                       hyper_cs_n_o,
    output logic                       hyper_cmd_valid_o,
    output hyper_read_pkg::hyper_cmd_t hyper_cmd_o,
    input  logic [7:0]                 hyper_dq_i,
    input  logic                       hyper_rwds_en_i
);

    import hyper_read_pkg::*;

    logic [1:0] q_valid;
    logic [1:0] q_ready;
    rd_req_t    q0_req;
    rd_req_t    q1_req;
    logic       grant_valid;
    logic       grant_ready;
    rd_req_t    grant_req;
    client_id_t grant_id;
    logic       cap_valid;
    rd_word_t   cap_word;
    logic       buf_valid;
    logic       buf_ready;
    rd_word_t   buf_word;
    rd_word_t   resp_word;

    // Request queues, one per client
    hyper_rd_fifo #(.T(rd_req_t), .DEPTH(REQ_FIFO_DEPTH)) i_req_fifo0 (
        .clk_rwds        (clk_rwds),
        .resetReadModule (resetReadModule),
        .push_valid_i    (req0_valid_i),
        .push_ready_o    (req0_ready_o),
        .push_data_i     (req0_i),
        .pop_valid_o     (q_valid[0]),
        .pop_ready_i     (q_ready[0]),
        .pop_data_o      (q0_req)
    );

    hyper_rd_fifo #(.T(rd_req_t), .DEPTH(REQ_FIFO_DEPTH)) i_req_fifo1 (
        .clk_rwds        (clk_rwds),
        .resetReadModule (resetReadModule),
        .push_valid_i    (req1_valid_i),
        .push_ready_o    (req1_ready_o),
        .push_data_i     (req1_i),
        .pop_valid_o     (q_valid[1]),
        .pop_ready_i     (q_ready[1]),
        .pop_data_o      (q1_req)
    );

    hyper_rd_arbiter i_arbiter (
        .clk_rwds        (clk_rwds),
        .resetReadModule (resetReadModule),
        .req_valid_i     (q_valid),
        .req_ready_o     (q_ready),
        .req0_i          (q0_req),
        .req1_i          (q1_req),
        .grant_valid_o   (grant_valid),
        .grant_ready_i   (grant_ready),
        .grant_req_o     (grant_req),
        .grant_id_o      (grant_id)
    );

    hyper_ddr_capture i_capture (
        .clk_rwds        (clk_rwds),
        .resetReadModule (resetReadModule),
        .hyper_dq_i      (hyper_dq_i),
        .hyper_rwds_en_i (hyper_rwds_en_i),
        .word_valid_o    (cap_valid),
        .word_o          (cap_word)
    );

    // Sized for one burst, so the capture side never needs ready
    hyper_rd_fifo #(.T(rd_word_t), .DEPTH(WORD_FIFO_DEPTH)) i_word_fifo (
        .clk_rwds        (clk_rwds),
        .resetReadModule (resetReadModule),
        .push_valid_i    (cap_valid),
        .push_ready_o    (),
        .push_data_i     (cap_word),
        .pop_valid_o     (buf_valid),
        .pop_ready_i     (buf_ready),
        .pop_data_o      (buf_word)
    );

    hyper_burst_ctrl i_burst_ctrl (
        .clk_rwds          (clk_rwds),
        .resetReadModule   (resetReadModule),
        .grant_valid_i     (grant_valid),
        .grant_ready_o     (grant_ready),
        .grant_req_i       (grant_req),
        .grant_id_i        (grant_id),
        .hyper_cs_n_o      (hyper_cs_n_o),
        .hyper_cmd_valid_o (hyper_cmd_valid_o),
        .hyper_cmd_o       (hyper_cmd_o),
        .word_valid_i      (buf_valid),
        .word_ready_o      (buf_ready),
        .word_i            (buf_word),
        .resp_valid_o      ({resp1_valid_o, resp0_valid_o}),
        .resp_ready_i      ({resp1_ready_i, resp0_ready_i}),
        .resp_o            (resp_word)
    );

    // Both ports share the payload, valid selects the owner
    assign resp0_o = resp_word;
    assign resp1_o = resp_word;

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the HyperBus read testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_hyper_read -f all.f -o tb_hyper_read

./obj_dir/tb_hyper_read | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "Simulation PASSED"
else
    echo "Simulation FAILED"
    exit 1
fi

// File: tests/hyper_ram_model.sv
`timescale 1ns/100ps

module hyper_ram_model (
    input  logic                       clk_rwds,
    input  logic                       resetReadModule,

    input  logic                       hyper_cs_n_i,
    input  logic                       hyper_cmd_valid_i,
    input  hyper_read_pkg::hyper_cmd_t hyper_cmd_i,

    output logic [7:0]                 hyper_dq_o,
    output logic                       hyper_rwds_en_o
);

    import hyper_read_pkg::*;

    // Cycles from the command to the first upper byte on DQ
    localparam int LATENCY = 6;
    localparam logic [15:0] DATA_MASK = 16'hA5C3;

    // Memory contents are a pure function of the word address
    function automatic logic [15:0] mem_word(input logic [ADDR_W-1:0] addr);
        return addr[15:0] ^ DATA_MASK;
    endfunction

    // Outputs move 1 ns after a clock edge, clear of both capture edges
    task automatic play_burst(input hyper_cmd_t cmd);
        logic [15:0] w;
        int          k;
        repeat (LATENCY - 1) @(negedge clk_rwds);
        for (k = 0; k <= int'(cmd.len); k++) begin
            #1;
            w               = mem_word(cmd.addr + ADDR_W'(k));
            hyper_dq_o      = w[15:8];
            hyper_rwds_en_o = 1'b1;
            @(posedge clk_rwds);
            #1;
            hyper_dq_o = w[7:0];
            @(negedge clk_rwds);
        end
        #1;
        hyper_dq_o      = 8'h00;
        hyper_rwds_en_o = 1'b0;
    endtask

    initial begin
        hyper_dq_o      = 8'h00;
        hyper_rwds_en_o = 1'b0;
        forever begin
            // The command pulse is stable at the falling edge
            @(negedge clk_rwds);
            if (!resetReadModule && hyper_cmd_valid_i && !hyper_cs_n_i) begin
                play_burst(hyper_cmd_i);
            end
        end
    end

endmodule

// File: tests/tb_hyper_read.sv
`timescale 1ns/100ps

module tb_hyper_read;

    import hyper_read_pkg::*;

    localparam int CLK_PERIOD = 10;
    // Worst case words: single burst, contention, back-pressure, queued
    localparam int MAX_TEST_WORDS = 8 + 4 * MAX_BURST + 2 * MAX_BURST + 4 * MAX_BURST;
    localparam int WATCHDOG_CYCLES = MAX_TEST_WORDS * 40 + 500;
    localparam logic [31:0] SEED = 32'h8714_3357;
    localparam logic [15:0] DATA_MASK = 16'hA5C3;

    logic        clk_rwds = 1'b0;
    logic        resetReadModule;
    logic        req0_valid;
    logic        req0_ready;
    rd_req_t     req0;
    logic        req1_valid;
    logic        req1_ready;
    rd_req_t     req1;
    logic        resp0_valid;
    logic        resp0_ready;
    rd_word_t    resp0_word;
    logic        resp1_valid;
    logic        resp1_ready;
    rd_word_t    resp1_word;
    logic        cs_n;
    logic        cmd_valid;
    hyper_cmd_t  cmd;
    logic [7:0]  dq;
    logic        rwds_en;

    rd_word_t    exp_words0[$];
    rd_word_t    exp_words1[$];
    hyper_cmd_t  exp_cmds[$];
    int          outstanding = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;
    string       test_name;
    logic [31:0] rng_state;
    logic [31:0] stall_state;
    int          stall_left;
    logic        stall_en;
    client_id_t  last_served;

    hyper_read_top dut0 (
        .clk_rwds          (clk_rwds),
        .resetReadModule   (resetReadModule),
        .req0_valid_i      (req0_valid),
        .req0_ready_o      (req0_ready),
        .req0_i            (req0),
        .req1_valid_i      (req1_valid),
        .req1_ready_o      (req1_ready),
        .req1_i            (req1),
        .resp0_valid_o     (resp0_valid),
        .resp0_ready_i     (resp0_ready),
        .resp0_o           (resp0_word),
        .resp1_valid_o     (resp1_valid),
        .resp1_ready_i     (resp1_ready),
        .resp1_o           (resp1_word),
        .hyper_cs_n_o      (cs_n),
        .hyper_cmd_valid_o (cmd_valid),
        .hyper_cmd_o       (cmd),
        .hyper_dq_i        (dq),
        .hyper_rwds_en_i   (rwds_en)
    );

    hyper_ram_model ram0 (
        .clk_rwds          (clk_rwds),
        .resetReadModule   (resetReadModule),
        .hyper_cs_n_i      (cs_n),
        .hyper_cmd_valid_i (cmd_valid),
        .hyper_cmd_i       (cmd),
        .hyper_dq_o        (dq),
        .hyper_rwds_en_o   (rwds_en)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [LEN_W-1:0] random_len();
        rng_state = xorshift32(rng_state);
        return {1'b0, rng_state[3:0]};
    endfunction

    function automatic rd_req_t random_req(input logic [LEN_W-1:0] len);
        rd_req_t r;
        rng_state = xorshift32(rng_state);
        r.addr    = rng_state;
        r.len     = len;
        return r;
    endfunction

    function automatic hyper_cmd_t to_cmd(input rd_req_t r);
        return '{addr: r.addr, len: r.len};
    endfunction

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: %s expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_word(input client_id_t id, input rd_word_t exp, input rd_word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: resp%0d expected data %h last %b actual data %h last %b",
                     test_name, id, exp.data, exp.last, act.data, act.last);
        end
    endtask

    task automatic check_cmd(input hyper_cmd_t exp, input hyper_cmd_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[FAIL] %s: command expected addr %h len %0d actual addr %h len %0d",
                     test_name, exp.addr, exp.len, act.addr, act.len);
        end
    endtask

    // Word k of a burst at A holds (A + k) XOR 16'hA5C3, last on the final word
    task automatic expect_burst(input client_id_t id, input rd_req_t r);
        rd_word_t          w;
        logic [ADDR_W-1:0] a;
        int                k;
        for (k = 0; k <= int'(r.len); k++) begin
            a      = r.addr + ADDR_W'(k);
            w.data = a[15:0] ^ DATA_MASK;
            w.last = (k == int'(r.len));
            if (id) begin
                exp_words1.push_back(w);
            end else begin
                exp_words0.push_back(w);
            end
        end
    endtask

    task automatic take_command();
        hyper_cmd_t c;
        check_bit("chip select at command", 1'b0, cs_n);
        if (exp_cmds.size() == 0) begin
            protocol_errors++;
            $display("%s: unexpected bus command to address %h", test_name, cmd.addr);
        end else begin
            c = exp_cmds.pop_front();
            check_cmd(c, cmd);
            if (outstanding != 0) begin
                protocol_errors++;
                $display("%s: new command while %0d words of the last burst were still pending",
                         test_name, outstanding);
            end
            outstanding = int'(c.len) + 1;
        end
    endtask

    task automatic take_word(input client_id_t id, input rd_word_t w);
        rd_word_t e;
        int       pending;
        pending = id ? exp_words1.size() : exp_words0.size();
        if (pending == 0) begin
            protocol_errors++;
            $display("%s: word %h arrived on resp%0d with no burst pending there",
                     test_name, w.data, id);
        end else begin
            if (id) begin
                e = exp_words1.pop_front();
            end else begin
                e = exp_words0.pop_front();
            end
            check_word(id, e, w);
            outstanding--;
        end
    endtask

    // Ready on resp1 flips after random stretches of 1 to 8 cycles
    task automatic update_resp1_ready();
        if (!stall_en) begin
            resp1_ready = 1'b1;
        end else begin
            if (stall_left == 0) begin
                stall_state = xorshift32(stall_state);
                resp1_ready = ~resp1_ready;
                stall_left  = int'(stall_state[2:0]) + 1;
            end
            stall_left--;
        end
    endtask

    // Offers both request lists, each entry held until its queue accepts it
    task automatic push_requests(input rd_req_t q0[$], input rd_req_t q1[$]);
        rd_req_t p0[$];
        rd_req_t p1[$];
        p0 = q0;
        p1 = q1;
        while (p0.size() > 0 || p1.size() > 0) begin
            @(negedge clk_rwds);
            req0_valid = (p0.size() > 0);
            req1_valid = (p1.size() > 0);
            if (req0_valid) begin
                req0 = p0[0];
            end
            if (req1_valid) begin
                req1 = p1[0];
            end
            if (req0_valid && req0_ready) begin
                void'(p0.pop_front());
            end
            if (req1_valid && req1_ready) begin
                void'(p1.pop_front());
            end
        end
        @(negedge clk_rwds);
        req0_valid = 1'b0;
        req1_valid = 1'b0;
    endtask

    task automatic wait_done(input int words);
        int cycles;
        int limit;
        cycles = 0;
        limit  = words * 40 + 100;
        while ((exp_cmds.size() != 0 || exp_words0.size() != 0 || exp_words1.size() != 0
                || outstanding != 0) && cycles < limit) begin
            @(negedge clk_rwds);
            cycles++;
        end
        if (cycles >= limit) begin
            protocol_errors++;
            $display("%s: timed out with %0d commands and %0d words still expected", test_name,
                     exp_cmds.size(), exp_words0.size() + exp_words1.size());
            exp_cmds.delete();
            exp_words0.delete();
            exp_words1.delete();
            outstanding = 0;
        end
        // A few idle cycles catch stray words or commands
        repeat (4) @(negedge clk_rwds);
    endtask

    task automatic test_reset_state();
        test_name = "reset state";
        check_bit("resp0 valid", 1'b0, resp0_valid);
        check_bit("resp1 valid", 1'b0, resp1_valid);
        check_bit("command valid", 1'b0, cmd_valid);
        check_bit("chip select", 1'b1, cs_n);
        check_bit("req0 ready", 1'b1, req0_ready);
        check_bit("req1 ready", 1'b1, req1_ready);
    endtask

    task automatic test_single_burst();
        rd_req_t q0[$];
        rd_req_t q1[$];
        test_name = "single burst";
        q0.push_back(random_req(5'd7));
        exp_cmds.push_back(to_cmd(q0[0]));
        expect_burst(1'b0, q0[0]);
        push_requests(q0, q1);
        wait_done(8);
        last_served = 1'b0;
    endtask

    task automatic test_contention();
        rd_req_t    qa[$];
        rd_req_t    qb[$];
        client_id_t first;
        int         words;
        int         i;
        test_name = "contention";
        first     = ~last_served;
        words     = 0;
        for (i = 0; i < 2; i++) begin
            qa.push_back(random_req(random_len()));
            qb.push_back(random_req(random_len()));
        end
        // The tie goes to the client not served last, then grants alternate
        for (i = 0; i < 2; i++) begin
            exp_cmds.push_back(to_cmd(qa[i]));
            exp_cmds.push_back(to_cmd(qb[i]));
            expect_burst(first, qa[i]);
            expect_burst(~first, qb[i]);
            words += int'(qa[i].len) + int'(qb[i].len) + 2;
        end
        if (first) begin
            push_requests(qb, qa);
        end else begin
            push_requests(qa, qb);
        end
        wait_done(words);
        last_served = ~first;
    endtask

    task automatic test_back_pressure();
        rd_req_t q0[$];
        rd_req_t q1[$];
        int      words;
        int      i;
        test_name = "back-pressure";
        words     = 0;
        q1.push_back(random_req(LEN_W'(MAX_BURST - 1)));
        // A second burst shows whether a command slips out early
        q1.push_back(random_req(random_len()));
        for (i = 0; i < 2; i++) begin
            exp_cmds.push_back(to_cmd(q1[i]));
            expect_burst(1'b1, q1[i]);
            words += int'(q1[i].len) + 1;
        end
        stall_en = 1'b1;
        push_requests(q0, q1);
        wait_done(words);
        stall_en    = 1'b0;
        last_served = 1'b1;
    endtask

    task automatic test_queued_requests();
        rd_req_t q0[$];
        rd_req_t q1[$];
        int      words;
        int      i;
        test_name = "queued requests";
        words     = 0;
        for (i = 0; i < 4; i++) begin
            q0.push_back(random_req(random_len()));
            exp_cmds.push_back(to_cmd(q0[i]));
            expect_burst(1'b0, q0[i]);
            words += int'(q0[i].len) + 1;
        end
        push_requests(q0, q1);
        wait_done(words);
        last_served = 1'b0;
    endtask

    initial begin
        forever #(CLK_PERIOD / 2) clk_rwds = ~clk_rwds;
    end

    // Bus and response monitor, commands first since they were issued earlier
    initial begin
        resp1_ready = 1'b1;
        stall_left  = 0;
        stall_state = xorshift32(SEED);
        forever begin
            @(negedge clk_rwds);
            if (!resetReadModule) begin
                if (cmd_valid) begin
                    take_command();
                end
                update_resp1_ready();
                if (resp0_valid && resp0_ready) begin
                    take_word(1'b0, resp0_word);
                end
                if (resp1_valid && resp1_ready) begin
                    take_word(1'b1, resp1_word);
                end
            end
        end
    end

    initial begin
        resetReadModule = 1'b1;
        req0_valid      = 1'b0;
        req0            = '0;
        req1_valid      = 1'b0;
        req1            = '0;
        resp0_ready     = 1'b1;
        stall_en        = 1'b0;
        rng_state       = SEED;
        last_served     = 1'b1;
        test_name       = "reset";
        repeat (8) @(posedge clk_rwds);
        @(negedge clk_rwds);
        resetReadModule = 1'b0;
        test_reset_state();
        test_single_burst();
        test_contention();
        test_back_pressure();
        test_queued_requests();
        $display("Summary: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_rwds);
        $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
        $display("tests failed");
        $finish;
    end

endmodule
